// File: verilog.f
source/corr_pkg.sv
source/cmd_parser.sv
source/line_conditioner.sv
source/pulse_correlator.sv
source/frame_serializer.sv
source/correlator_top.sv
test/tb_correlator.sv

// File: test/tb_correlator.sv
// ==========================================================
// directed tests; lines are held steady across each window.
// watchdog ends the run after 6 tests of 2000 cycles each.
// ==========================================================

module tb_correlator import corr_pkg::*; ();

	logic intclk;
	logic rst_n;
	logic [7:0] cmd_byte;
	logic cmd_valid;
	logic [3:0] line_in;
	logic [7:0] tx_byte;
	logic tx_valid;
	logic integrating;

	// stimulus and model state.
	logic [3:0] line_level;
	logic [3:0] toggle_mask;
	logic [3:0] inv_model;
	logic [3:0] edge_model;
	logic phase;
	logic [7:0] rx_q [$];
	logic [7:0] exp_frame [frame_bytes];
	logic tx_last;
	int tx_bursts;
	int integ_cycles;
	int errors;
	int tests_run;
	int tests_failed;

	correlator_top uut (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.cmd_byte    (cmd_byte),
		.cmd_valid   (cmd_valid),
		.line_in     (line_in),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.integrating (integrating)
	);

	always #4 intclk = ~intclk;

	// toggled lines flip on every rising edge.
	always @(posedge intclk) begin
		phase <= ~phase;
		line_in <= line_level ^ (toggle_mask & {4{phase}});
	end

	// outputs are sampled on the falling edge.
	always @(negedge intclk) begin
		if (tx_valid) rx_q.push_back(tx_byte);
		if (tx_valid && !tx_last) tx_bursts++;
		if (integrating) integ_cycles++;
		tx_last = tx_valid;
	end

	// ==========================================================
	// helpers.
	// ==========================================================
	task automatic send_cmd(input logic [7:0] value);
		@(posedge intclk);
		cmd_byte <= value;
		cmd_valid <= 1'b1;
		@(posedge intclk);
		cmd_valid <= 1'b0;
	endtask

	task automatic set_channel(input int chan, input logic inv, input logic edge_on);
		send_cmd({op_config, 2'(chan), inv, edge_on, 2'b00});
		inv_model[chan] = inv;
		edge_model[chan] = edge_on;
	endtask

	task automatic drive_lines(input logic [3:0] level, input logic [3:0] toggles);
		@(posedge intclk);
		line_level <= level;
		toggle_mask <= toggles;
	endtask

	// expected frame from the effective line values.
	function automatic void build_expected(input int win_len);
		logic [3:0] eff;
		logic [15:0] cnt;
		for (int i = 0; i < 4; i++) begin
			eff[i] = edge_model[i] ? toggle_mask[i] : (line_level[i] ^ inv_model[i]);
		end
		exp_frame[0] = 8'hA5;
		for (int i = 0; i < 4; i++) begin
			cnt = eff[i] ? 16'(win_len) : 16'd0;
			exp_frame[1 + 2*i] = cnt[15:8];
			exp_frame[2 + 2*i] = cnt[7:0];
		end
		for (int b = 0; b < 6; b++) begin
			cnt = (eff[base_first[b]] && eff[base_second[b]]) ? 16'(win_len) : 16'd0;
			exp_frame[9 + 2*b] = cnt[15:8];
			exp_frame[10 + 2*b] = cnt[7:0];
		end
	endfunction

	// one window, one frame, then compare.
	task automatic run_window(input int len, input bit retrigger);
		int wait_cnt;
		int win_len;
		win_len = (len + 2) * 16;
		repeat (6) @(posedge intclk);
		build_expected(win_len);
		rx_q.delete();
		tx_bursts = 0;
		integ_cycles = 0;
		send_cmd({op_integrate, 6'(len)});
		// integrating rises on the cycle after the strobe.
		@(negedge intclk);
		assert (integrating) else begin
			$display("window did not open the cycle after the integrate command at %0t",
				$time);
			errors++;
		end
		if (retrigger) begin
			repeat (8) @(posedge intclk);
			send_cmd({op_integrate, 6'd20});
		end
		wait_cnt = 0;
		while (rx_q.size() < frame_bytes && wait_cnt < win_len + 60) begin
			@(negedge intclk);
			wait_cnt++;
		end
		// room for stray bytes to show up.
		repeat (30) @(negedge intclk);
		assert (integ_cycles == win_len) else begin
			$display("MISMATCH time=%0t signal=integrating_cycles got=%0d expected=%0d",
				$time, integ_cycles, win_len);
			errors++;
		end
		assert (rx_q.size() >= frame_bytes) else begin
			$display("missing frame: only %0d of %0d bytes arrived", rx_q.size(), frame_bytes);
			errors++;
		end
		assert (rx_q.size() <= frame_bytes) else begin
			$display("extra frame: %0d bytes arrived, %0d expected", rx_q.size(), frame_bytes);
			errors++;
		end
		assert (tx_bursts <= 1) else begin
			$display("frame not contiguous: tx_valid rose %0d times, once expected", tx_bursts);
			errors++;
		end
		for (int k = 0; k < frame_bytes && k < rx_q.size(); k++) begin
			assert (rx_q[k] == exp_frame[k]) else begin
				$display("MISMATCH time=%0t signal=tx_byte[%0d] got=%h expected=%h",
					$time, k, rx_q[k], exp_frame[k]);
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors > errors_before) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	// ==========================================================
	// tests.
	// ==========================================================
	task automatic stay_idle_after_reset();
		int e0;
		e0 = errors;
		repeat (50) begin
			@(negedge intclk);
			assert (!tx_valid) else begin
				$display("MISMATCH time=%0t signal=tx_valid got=%b expected=0", $time, tx_valid);
				errors++;
			end
			assert (!integrating) else begin
				$display("MISMATCH time=%0t signal=integrating got=%b expected=0",
					$time, integrating);
				errors++;
			end
		end
		report_test("idle", e0);
	endtask

	task automatic count_steady_levels();
		int e0;
		e0 = errors;
		drive_lines(4'b1011, 4'b0000);
		run_window(0, 1'b0);
		report_test("level", e0);
	endtask

	task automatic count_inverted_channel();
		int e0;
		e0 = errors;
		set_channel(2, 1'b1, 1'b0);
		drive_lines(4'b0111, 4'b0000);
		run_window($urandom_range(0, 63), 1'b0);
		report_test("inversion", e0);
	endtask

	task automatic count_toggling_edges();
		int e0;
		logic [3:0] subset;
		e0 = errors;
		subset = 4'($urandom_range(1, 15));
		for (int i = 0; i < 4; i++) begin
			set_channel(i, 1'b0, subset[i]);
		end
		drive_lines(4'b1111, subset);
		run_window($urandom_range(0, 15), 1'b0);
		report_test("edge", e0);
	endtask

	task automatic clear_then_count();
		int e0;
		e0 = errors;
		set_channel(0, 1'b1, 1'b1);
		set_channel(3, 1'b1, 1'b0);
		send_cmd({op_clear, 6'd0});
		inv_model = 4'b0000;
		edge_model = 4'b0000;
		drive_lines(4'b0110, 4'b0000);
		run_window(1, 1'b0);
		report_test("clear", e0);
	endtask

	task automatic ignore_second_integrate();
		int e0;
		e0 = errors;
		drive_lines(4'b1101, 4'b0000);
		run_window(3, 1'b1);
		report_test("retrigger", e0);
	endtask

	initial begin
		intclk = 1'b0;
		rst_n = 1'b0;
		cmd_byte = 8'h00;
		cmd_valid = 1'b0;
		line_in = 4'b0000;
		line_level = 4'b0000;
		toggle_mask = 4'b0000;
		inv_model = 4'b0000;
		edge_model = 4'b0000;
		phase = 1'b0;
		tx_last = 1'b0;
		tx_bursts = 0;
		integ_cycles = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(99777));
		repeat (3) @(posedge intclk);
		rst_n <= 1'b1;
		stay_idle_after_reset();
		count_steady_levels();
		count_inverted_channel();
		count_toggling_edges();
		clear_then_count();
		ignore_second_integrate();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// 6 tests x 2000 cycles x 8 time units.
	initial begin
		#(6 * 2000 * 8);
		$display("timeout: the tests did not finish in the allowed time");
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: source/correlator_top.sv
// ==========================================================
// single clock domain; line_in may be asynchronous.
// ==========================================================

module correlator_top import corr_pkg::*; (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [7:0]            cmd_byte,
	input  logic                  cmd_valid,
	input  logic [num_inputs-1:0] line_in,
	output logic [7:0]            tx_byte,
	output logic                  tx_valid,
	output logic                  integrating
);

	logic [num_inputs-1:0] invert_mask;
	logic [num_inputs-1:0] edge_mask;
	logic [num_inputs-1:0] pulses;
	logic [num_inputs*count_width-1:0] line_counts;
	logic [num_baselines*count_width-1:0] pair_counts;
	logic result_valid;

	cmd_parser u_cmd_parser (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.cmd_byte    (cmd_byte),
		.cmd_valid   (cmd_valid),
		.invert_mask (invert_mask),
		.edge_mask   (edge_mask),
		.integrating (integrating)
	);

	line_conditioner u_line_conditioner (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.edge_mask   (edge_mask),
		.pulses      (pulses)
	);

	pulse_correlator u_pulse_correlator (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.pulses       (pulses),
		.integrating  (integrating),
		.line_counts  (line_counts),
		.pair_counts  (pair_counts),
		.result_valid (result_valid)
	);

	frame_serializer u_frame_serializer (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.line_counts  (line_counts),
		.pair_counts  (pair_counts),
		.result_valid (result_valid),
		.tx_byte      (tx_byte),
		.tx_valid     (tx_valid)
	);

endmodule

// File: source/frame_serializer.sv
// ==========================================================
// one frame per snapshot, bytes on consecutive cycles.
// no back-pressure; counts go out msb first.
// ==========================================================

module frame_serializer import corr_pkg::*; (
	input  logic                                intclk,
	input  logic                                rst_n,
	input  logic [num_inputs*count_width-1:0]    line_counts,
	input  logic [num_baselines*count_width-1:0] pair_counts,
	input  logic                                result_valid,
	output logic [7:0]                          tx_byte,
	output logic                                tx_valid
);

	logic in_frame;
	logic [byte_idx_width-1:0] byte_idx;
	logic [byte_idx_width-1:0] byte_sel;
	logic [count_width-1:0] cur_word;
	logic [count_width-1:0] counts [num_inputs + num_baselines];

	// byte 1 maps to the high half of word 0.
	assign byte_sel = byte_idx - 1'b1;
	assign cur_word = counts[byte_sel[byte_idx_width-1:1]];

	// snapshot copy, lines first.
	always_ff @(posedge intclk) begin
		if (result_valid) begin
			for (int i = 0; i < num_inputs; i++) begin
				counts[i] <= line_counts[i*count_width +: count_width];
			end
			for (int b = 0; b < num_baselines; b++) begin
				counts[num_inputs + b] <= pair_counts[b*count_width +: count_width];
			end
		end
	end

	// ==========================================================
	// byte sequencer.
	// ==========================================================
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			in_frame <= 1'b0;
			byte_idx <= '0;
			tx_valid <= 1'b0;
		end else begin
			tx_valid <= 1'b0;
			if (result_valid) begin
				in_frame <= 1'b1;
				byte_idx <= byte_idx_width'(1);
				tx_valid <= 1'b1;
			end else if (in_frame) begin
				tx_valid <= 1'b1;
				if (byte_idx == byte_idx_width'(frame_bytes - 1)) begin
					in_frame <= 1'b0;
				end else begin
					byte_idx <= byte_idx + 1'b1;
				end
			end
		end
	end

	// marker first, then high and low halves.
	always_ff @(posedge intclk) begin
		if (result_valid) begin
			tx_byte <= frame_marker;
		end else if (in_frame) begin
			tx_byte <= byte_sel[0] ? cur_word[7:0] : cur_word[15:8];
		end
	end

	// windows are longer than frames.
	a_no_overlap: assert property (@(posedge intclk) disable iff (!rst_n)
		result_valid |-> !in_frame);

endmodule

// File: source/pulse_correlator.sv
// ==========================================================
// lag-zero counts per line and per pair, one snapshot per
// window. counters restart on the first window cycle.
// ==========================================================

module pulse_correlator import corr_pkg::*; (
	input  logic                                intclk,
	input  logic                                rst_n,
	input  logic [num_inputs-1:0]               pulses,
	input  logic                                integrating,
	output logic [num_inputs*count_width-1:0]    line_counts,
	output logic [num_baselines*count_width-1:0] pair_counts,
	output logic                                result_valid
);

	logic integ_d;
	logic win_start;
	logic win_end;
	logic [num_baselines-1:0] coinc;
	logic [count_width-1:0] line_cnt [num_inputs];
	logic [count_width-1:0] pair_cnt [num_baselines];

	assign win_start = integrating & ~integ_d;
	assign win_end = ~integrating & integ_d;

	// coincidences in baseline order.
	always_comb begin
		for (int b = 0; b < num_baselines; b++) begin
			coinc[b] = pulses[base_first[b]] & pulses[base_second[b]];
		end
	end

	// ==========================================================
	// window edges.
	// ==========================================================
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			integ_d <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			integ_d <= integrating;
			result_valid <= win_end;
		end
	end

	// ==========================================================
	// accumulation.
	// ==========================================================
	always_ff @(posedge intclk) begin
		if (integrating) begin
			for (int i = 0; i < num_inputs; i++) begin
				if (win_start) begin
					line_cnt[i] <= count_width'(pulses[i]);
				end else begin
					line_cnt[i] <= line_cnt[i] + count_width'(pulses[i]);
				end
			end
			for (int b = 0; b < num_baselines; b++) begin
				if (win_start) begin
					pair_cnt[b] <= count_width'(coinc[b]);
				end else begin
					pair_cnt[b] <= pair_cnt[b] + count_width'(coinc[b]);
				end
			end
		end
	end

	// snapshot, held until the next window closes.
	always_ff @(posedge intclk) begin
		if (win_end) begin
			for (int i = 0; i < num_inputs; i++) begin
				line_counts[i*count_width +: count_width] <= line_cnt[i];
			end
			for (int b = 0; b < num_baselines; b++) begin
				pair_counts[b*count_width +: count_width] <= pair_cnt[b];
			end
		end
	end

	// snapshot comes only after the window has closed.
	a_snap_outside_window: assert property (@(posedge intclk) disable iff (!rst_n)
		result_valid |-> !integrating);

endmodule

// File: source/line_conditioner.sv
// ==========================================================
// lines are asynchronous; three cycles to the pulse output.
// edge mode flags any change between consecutive samples.
// ==========================================================

module line_conditioner import corr_pkg::*; (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [num_inputs-1:0] line_in,
	input  logic [num_inputs-1:0] invert_mask,
	input  logic [num_inputs-1:0] edge_mask,
	output logic [num_inputs-1:0] pulses
);

	logic [num_inputs-1:0] sync_a;
	logic [num_inputs-1:0] sync_b;
	logic [num_inputs-1:0] sample;
	logic [num_inputs-1:0] prev_sample;

	assign sample = sync_b ^ invert_mask;

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			prev_sample <= '0;
			pulses <= '0;
		end else begin
			sync_a <= line_in;
			sync_b <= sync_a;
			prev_sample <= sample;
			// per line choice of level or change.
			for (int i = 0; i < num_inputs; i++) begin
				if (edge_mask[i]) begin
					pulses[i] <= sample[i] ^ prev_sample[i];
				end else begin
					pulses[i] <= sample[i];
				end
			end
		end
	end

endmodule

// File: source/cmd_parser.sv
// ==========================================================
// decodes one command byte per strobe, no acknowledge.
// a window request while a window is open is dropped.
// ==========================================================

module cmd_parser import corr_pkg::*; (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [7:0]            cmd_byte,
	input  logic                  cmd_valid,
	output logic [num_inputs-1:0] invert_mask,
	output logic [num_inputs-1:0] edge_mask,
	output logic                  integrating
);

	cmd_word_u cmd;
	logic [win_width-1:0] win_count;
	logic [win_width-1:0] win_load;

	assign cmd = cmd_byte;

	// last cycle of the window sits at count zero.
	assign win_load = win_width'((cmd.win_view.len + 2) * window_unit - 1);

	// channel settings.
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			invert_mask <= '0;
			edge_mask <= '0;
		end else if (cmd_valid) begin
			case (cmd.chan_view.op)
				op_config: begin
					invert_mask[cmd.chan_view.chan] <= cmd.chan_view.invert;
					edge_mask[cmd.chan_view.chan] <= cmd.chan_view.edge_mode;
				end
				op_clear: begin
					invert_mask <= '0;
					edge_mask <= '0;
				end
				// window handled by the timer below.
				op_integrate, op_none: ;
			endcase
		end
	end

	// integration window timer.
	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			integrating <= 1'b0;
			win_count <= '0;
		end else if (!integrating) begin
			if (cmd_valid && cmd.win_view.op == op_integrate) begin
				integrating <= 1'b1;
				win_count <= win_load;
			end
		end else if (win_count == '0) begin
			integrating <= 1'b0;
		end else begin
			win_count <= win_count - 1'b1;
		end
	end

	// a window only opens in response to a command.
	a_open_by_cmd: assert property (@(posedge intclk) disable iff (!rst_n)
		$rose(integrating) |-> $past(cmd_valid));

endmodule

// File: source/corr_pkg.sv
// ==========================================================
// sizes, opcodes and command layout shared by all blocks.
// counters are 16 bits wide; windows of up to 65 units fit.
// ==========================================================

package corr_pkg;

	// ==========================================================
	// array sizes.
	// ==========================================================
	localparam int num_inputs = 4;
	localparam int num_baselines = 6;
	localparam int count_width = 16;

	// integration granularity in clock cycles.
	localparam int window_unit = 16;

	// enough for (63 + 2) * 16 - 1.
	localparam int win_width = 11;

	// ==========================================================
	// frame layout.
	// ==========================================================
	localparam logic [7:0] frame_marker = 8'hA5;
	localparam int frame_bytes = 1 + 2 * (num_inputs + num_baselines);
	localparam int byte_idx_width = $clog2(frame_bytes);

	// line pairs at lag zero, in frame order.
	localparam int base_first [num_baselines] = '{0, 0, 0, 1, 1, 2};
	localparam int base_second [num_baselines] = '{1, 2, 3, 2, 3, 3};

	// ==========================================================
	// command byte.
	// ==========================================================
	localparam logic [1:0] op_config = 2'b00;
	localparam logic [1:0] op_integrate = 2'b01;
	localparam logic [1:0] op_clear = 2'b10;
	localparam logic [1:0] op_none = 2'b11;

	// per-channel setup.
	typedef struct packed {
		logic [1:0] op;
		logic [1:0] chan;
		logic invert;
		logic edge_mode;
		logic [1:0] reserved;
	} chan_view_t;

	// window length in units, offset by two.
	typedef struct packed {
		logic [1:0] op;
		logic [5:0] len;
	} win_view_t;

	typedef union packed {
		chan_view_t chan_view;
		win_view_t win_view;
	} cmd_word_u;

endpackage
